// File: common/memPkg.sv
// ##############################
// shared widths, enums and structs
// for the data cache memory stage.
// ##############################
`default_nettype none

package memPkg;

   localparam int WORD_W  = 16;          // data and byte address width.
   localparam int MADDR_W = WORD_W - 1;  // word index width.

   // command from the execute stage after decode.
   typedef enum logic [1:0] {
      OP_NONE = 2'd0,
      OP_RD   = 2'd1,
      OP_WR   = 2'd2
   } memOpE;

   // cache controller states.
   typedef enum logic [2:0] {
      S_IDLE      = 3'd0,
      S_HIT       = 3'd1,  // tag compare on latched address.
      S_FILL_REQ  = 3'd2,  // read miss, req high until ack.
      S_FILL_WAIT = 3'd3,  // req low, wait for ack to drop.
      S_WT_REQ    = 3'd4,  // write-through, req high until ack.
      S_WT_WAIT   = 3'd5,
      S_DONE      = 3'd6,
      S_ERR       = 3'd7   // misaligned access.
   } cacheStateE;

   // cache to backing memory, four-phase.
   typedef struct packed {
      logic               req;
      logic               wr;
      logic [MADDR_W-1:0] addr;   // word index.
      logic [WORD_W-1:0]  wdata;
   } memReqS;

   // backing memory to cache.
   typedef struct packed {
      logic              ack;
      logic [WORD_W-1:0] rdata;   // valid while ack is high.
   } memRespS;

endpackage

`default_nettype wire

// File: dcache/cacheArray.sv
// ##############################
// direct-mapped tag, valid and data
// arrays with combinational lookup.
// ##############################
`default_nettype none

module cacheArray #(
   parameter int INDEX_W = 3
) (
   input  logic                                clk,
   input  logic                                rstN,
   input  logic [INDEX_W-1:0]                  index,
   input  logic [memPkg::MADDR_W-INDEX_W-1:0]  tag,
   input  logic                                wrEn,
   input  logic [memPkg::WORD_W-1:0]           wrData,
   output logic                                hit,
   output logic [memPkg::WORD_W-1:0]           rdData
);

   localparam int LINES = 2 ** INDEX_W;
   localparam int TAG_W = memPkg::MADDR_W - INDEX_W;

   logic [LINES-1:0]          valid;
   logic [TAG_W-1:0]          tagMem  [LINES];
   logic [memPkg::WORD_W-1:0] dataMem [LINES];

   // valid bits are the only state cleared by reset.
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         valid <= '0;
      end else if (wrEn) begin
         valid[index] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (wrEn) begin
         tagMem[index]  <= tag;     // fill or write hit, tag is the same either way.
         dataMem[index] <= wrData;
      end
   end

   // lookup on the current index.
   assign hit    = valid[index] && (tagMem[index] == tag);
   assign rdData = dataMem[index];

endmodule

`default_nettype wire

// File: dcache/cacheCtrl.sv
// ##############################
// data cache FSM: hit check, fill,
// write-through, misalign error.
// ##############################
`default_nettype none

module cacheCtrl (
   input  logic                       clk,
   input  logic                       rstN,
   input  memPkg::memOpE              op,
   input  logic                       enable,
   input  logic [memPkg::WORD_W-1:0]  addr,
   input  logic [memPkg::WORD_W-1:0]  wdata,
   input  logic                       tagHit,
   input  logic [memPkg::WORD_W-1:0]  arrayData,
   input  memPkg::memRespS            resp,
   output memPkg::memReqS             req,
   output logic                       arrayWr,
   output logic [memPkg::WORD_W-1:0]  arrayWdata,
   output logic [memPkg::WORD_W-1:0]  rdata,
   output logic                       done,
   output logic                       busy,
   output logic                       cacheHit,
   output logic                       err
);

   memPkg::cacheStateE         state, nextState;
   memPkg::memOpE              opQ;
   logic [memPkg::MADDR_W-1:0] addrQ;    // word index of the access.
   logic [memPkg::WORD_W-1:0]  wdataQ;
   logic [memPkg::WORD_W-1:0]  rdataQ;
   logic                       hitQ;
   logic                       accept;
   logic                       isWr;

   assign accept = (state == memPkg::S_IDLE) && enable && (op != memPkg::OP_NONE);
   assign isWr   = (opQ == memPkg::OP_WR);

   always_comb begin
      nextState = state;
      case (state)
         memPkg::S_IDLE:      if (accept) nextState = addr[0] ? memPkg::S_ERR : memPkg::S_HIT;
         memPkg::S_HIT: begin
            if (isWr)         nextState = memPkg::S_WT_REQ;   // always write through.
            else if (!tagHit) nextState = memPkg::S_FILL_REQ;
            else              nextState = memPkg::S_DONE;
         end
         memPkg::S_FILL_REQ:  if (resp.ack)  nextState = memPkg::S_FILL_WAIT;
         memPkg::S_FILL_WAIT: if (!resp.ack) nextState = memPkg::S_DONE;
         memPkg::S_WT_REQ:    if (resp.ack)  nextState = memPkg::S_WT_WAIT;
         memPkg::S_WT_WAIT:   if (!resp.ack) nextState = memPkg::S_DONE;
         default:             nextState = memPkg::S_IDLE;     // done and err last one cycle.
      endcase
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         state <= memPkg::S_IDLE;
         opQ   <= memPkg::OP_NONE;
         hitQ  <= 1'b0;
      end else begin
         state <= nextState;
         if (accept) opQ <= op;                           // inputs ignored after this.
         if (state == memPkg::S_HIT) hitQ <= tagHit;
         else if (accept) hitQ <= 1'b0;
      end
   end

   // payload capture.
   always_ff @(posedge clk) begin
      if (accept) begin
         addrQ  <= addr[memPkg::WORD_W-1:1];
         wdataQ <= wdata;
      end
      if (state == memPkg::S_HIT) rdataQ <= isWr ? wdataQ : arrayData;
      else if (state == memPkg::S_FILL_REQ && resp.ack) rdataQ <= resp.rdata;
   end

   // write hit updates the word, fill loads the line. no allocate on write miss.
   assign arrayWr = ((state == memPkg::S_HIT) && isWr && tagHit) ||
                    ((state == memPkg::S_FILL_REQ) && resp.ack);
   assign arrayWdata = (state == memPkg::S_FILL_REQ) ? resp.rdata : wdataQ;

   assign req.req   = (state == memPkg::S_FILL_REQ) || (state == memPkg::S_WT_REQ);
   assign req.wr    = isWr;
   assign req.addr  = addrQ;   // held stable from accept to done.
   assign req.wdata = wdataQ;

   assign rdata    = rdataQ;
   assign done     = (state == memPkg::S_DONE) || (state == memPkg::S_ERR);
   assign err      = (state == memPkg::S_ERR);
   assign cacheHit = (state == memPkg::S_DONE) && hitQ;
   assign busy     = accept || !((state == memPkg::S_IDLE) || done);

   // four-phase: req held until the memory acks.
   reqHoldA: assert property (@(posedge clk) disable iff (!rstN)
      $fell(req.req) |-> $past(resp.ack));
   // completion never overlaps a new acceptance or an open handshake.
   doneBusyA: assert property (@(posedge clk) disable iff (!rstN)
      done |-> !busy && !resp.ack);
   // error is a single-cycle done.
   errPulseA: assert property (@(posedge clk) disable iff (!rstN)
      err |-> done ##1 !err);

endmodule

`default_nettype wire

// File: verilog/mainMem.sv
// ##############################
// backing word memory, fixed latency
// behind a four-phase req/ack.
// ##############################
`default_nettype none

module mainMem #(
   parameter int MEM_LAT = 4
) (
   input  logic            clk,
   input  logic            rstN,
   input  memPkg::memReqS  req,
   output memPkg::memRespS resp
);

   localparam int WORDS = 2 ** memPkg::MADDR_W;
   localparam int CNT_W = $clog2(MEM_LAT + 1);

   logic [memPkg::WORD_W-1:0] mem [WORDS];
   logic [CNT_W-1:0]          latCnt;
   logic                      ackQ;
   logic [memPkg::WORD_W-1:0] rdataQ;
   logic                      fire;   // last latency cycle, ack next.

   assign fire = req.req && !ackQ && (latCnt == CNT_W'(MEM_LAT - 1));

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         latCnt <= '0;
         ackQ   <= 1'b0;
      end else if (!req.req) begin
         latCnt <= '0;
         ackQ   <= 1'b0;       // phase 4, drop after req falls.
      end else if (fire) begin
         latCnt <= '0;
         ackQ   <= 1'b1;
      end else if (!ackQ) begin
         latCnt <= latCnt + 1'b1;
      end
   end

   // reset contents: word w holds w ^ a5a5.
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int w = 0; w < WORDS; w++) mem[w] <= 16'(w) ^ 16'hA5A5;
      end else if (fire && req.wr) begin
         mem[req.addr] <= req.wdata;
      end
   end

   always_ff @(posedge clk) if (fire) rdataQ <= mem[req.addr];

   assign resp.ack   = ackQ;
   assign resp.rdata = rdataQ;

   ackRiseA: assert property (@(posedge clk) disable iff (!rstN)
      $rose(resp.ack) |-> req.req);

endmodule

`default_nettype wire

// File: dcache/memSystem.sv
// ##############################
// data cache: controller, array and
// backing memory.
// ##############################
`default_nettype none

module memSystem #(
   parameter int INDEX_W = 3,
   parameter int MEM_LAT = 4
) (
   input  logic                       clk,
   input  logic                       rstN,
   input  memPkg::memOpE              op,
   input  logic                       enable,
   input  logic [memPkg::WORD_W-1:0]  addr,
   input  logic [memPkg::WORD_W-1:0]  wdata,
   output logic [memPkg::WORD_W-1:0]  rdata,
   output logic                       done,
   output logic                       busy,
   output logic                       cacheHit,
   output logic                       err
);

   localparam int TAG_W = memPkg::MADDR_W - INDEX_W;

   memPkg::memReqS            memReq;
   memPkg::memRespS           memResp;
   logic                      tagHit;
   logic                      arrayWr;
   logic [memPkg::WORD_W-1:0] arrayData;
   logic [memPkg::WORD_W-1:0] arrayWdata;
   logic [INDEX_W-1:0]        index;
   logic [TAG_W-1:0]          tag;

   // the latched word index drives the lookup, not the raw input.
   assign index = memReq.addr[INDEX_W-1:0];
   assign tag   = memReq.addr[memPkg::MADDR_W-1:INDEX_W];

   cacheCtrl i_cacheCtrl (
      .clk, .rstN, .op, .enable, .addr, .wdata,
      .tagHit, .arrayData, .resp(memResp), .req(memReq),
      .arrayWr, .arrayWdata, .rdata, .done, .busy, .cacheHit, .err
   );

   cacheArray #(.INDEX_W(INDEX_W)) i_cacheArray (
      .clk, .rstN, .index, .tag,
      .wrEn(arrayWr), .wrData(arrayWdata), .hit(tagHit), .rdData(arrayData)
   );

   mainMem #(.MEM_LAT(MEM_LAT)) i_mainMem (
      .clk, .rstN, .req(memReq), .resp(memResp)
   );

endmodule

`default_nettype wire

// File: verilog/memory.sv
// ##############################
// memory stage top, command decode
// and stall handling.
// ##############################
`default_nettype none

module memory #(
   parameter int INDEX_W = 3,   // 8 lines.
   parameter int MEM_LAT = 4
) (
   input  logic                      clk,
   input  logic                      rstN,
   input  logic [memPkg::WORD_W-1:0] dataAddr,
   input  logic [memPkg::WORD_W-1:0] wrtData,
   input  logic                      memWrt,
   input  logic                      readEn,
   input  logic                      istall,
   input  logic                      istallM,
   output logic [memPkg::WORD_W-1:0] memOut,
   output logic                      done,
   output logic                      cacheHit,
   output logic                      dstall,
   output logic                      dcacheErr
);

   memPkg::memOpE op;
   logic          enable;
   logic          cacheBusy;

   // write wins when both are set.
   always_comb begin
      if (memWrt)      op = memPkg::OP_WR;
      else if (readEn) op = memPkg::OP_RD;
      else             op = memPkg::OP_NONE;
   end

   // hold off new accesses only, in-flight ones still finish.
   assign enable = !(istall && istallM);
   assign dstall = cacheBusy | dcacheErr;

   memSystem #(.INDEX_W(INDEX_W), .MEM_LAT(MEM_LAT)) i_memSystem (
      .clk, .rstN, .op, .enable,
      .addr(dataAddr), .wdata(wrtData), .rdata(memOut),
      .done, .busy(cacheBusy), .cacheHit, .err(dcacheErr)
   );

endmodule

`default_nettype wire

// File: verif/memChecker.sv
// ##############################
// result checker for the memory stage,
// compares in the done cycle.
// ##############################
`default_nettype none

module memChecker (
   input  logic        clk,
   input  logic        rstN,
   input  logic [15:0] memOut,
   input  logic        done,
   input  logic        cacheHit,
   input  logic        dstall,
   input  logic        dcacheErr,
   input  logic        istall,
   input  logic        istallM,
   input  logic [15:0] expData,    // held by the testbench until the next access.
   input  logic        expHit,
   input  logic        expErr,
   input  logic        checkData,  // reads only.
   output int          valueErrs,
   output int          otherErrs,
   output int          doneCount
);

   logic dstallQ;   // dstall one falling edge back.

   task automatic valueMismatch(input string name, input logic [15:0] expV,
                                input logic [15:0] gotV);
      $display("CHECK FAILED t=%0t %s: expected %h, got %h", $time, name, expV, gotV);
      valueErrs++;
   endtask

   task automatic protocolFault(input string what);
      $display("t=%0t error: %s", $time, what);
      otherErrs++;
   endtask

   // idle outputs right after reset.
   initial begin
      valueErrs = 0;
      otherErrs = 0;
      doneCount = 0;
      dstallQ   = 1'b0;
      @(posedge rstN);
      @(negedge clk);
      if (done !== 1'b0)      valueMismatch("done", 16'd0, 16'(done));
      if (dstall !== 1'b0)    valueMismatch("dstall", 16'd0, 16'(dstall));
      if (dcacheErr !== 1'b0) valueMismatch("dcacheErr", 16'd0, 16'(dcacheErr));
   end

   // outputs settle after the rising edge, so compare on the falling one.
   always @(negedge clk) begin
      if (rstN && done) begin
         doneCount++;
         if (dcacheErr !== expErr) valueMismatch("dcacheErr", 16'(expErr), 16'(dcacheErr));
         if (cacheHit !== expHit)  valueMismatch("cacheHit", 16'(expHit), 16'(cacheHit));
         if (dstall !== expErr)    valueMismatch("dstall", 16'(expErr), 16'(dstall));
         if (checkData && (memOut !== expData)) valueMismatch("memOut", expData, memOut);
         if (!expErr && (dstallQ !== 1'b1))
            protocolFault("dstall was low in the cycle before a completed access");
      end
      if (rstN && done && istall && istallM)
         protocolFault("an access completed while istall and istallM were both high");
      if (rstN && dcacheErr && !done)
         protocolFault("dcacheErr was raised outside a done cycle");
      dstallQ = dstall;
   end

endmodule

`default_nettype wire

// File: verif/tbMemory.sv
// ##############################
// testbench top: clock, reset, vector
// driven stimulus and timeout.
// ##############################
`default_nettype none

module tbMemory;

   localparam int INDEX_W   = 3;
   localparam int MEM_LAT   = 4;
   localparam int STALL_CYC = 3;   // stall inputs held this long before an access.

   typedef struct packed {
      logic [3:0]  op;      // bit 0 readEn, bit 1 memWrt.
      logic [15:0] addr;
      logic [15:0] wdata;
      logic [15:0] rdata;   // expected memOut on reads.
      logic        hit;
      logic        err;
      logic        stall;
   } vecS;

   logic        clk;
   logic        rstN;
   logic [15:0] dataAddr;
   logic [15:0] wrtData;
   logic        memWrt;
   logic        readEn;
   logic        istall;
   logic        istallM;
   logic [15:0] memOut;
   logic        done;
   logic        cacheHit;
   logic        dstall;
   logic        dcacheErr;
   logic [15:0] expData;
   logic        expHit;
   logic        expErr;
   logic        checkData;
   int          valueErrs;
   int          otherErrs;
   int          doneCount;
   int          tbErrs = 0;
   int          cycleLimit = 0;   // set once the vectors are known.
   int          cycles;
   bit          loaded;
   vecS         vecQ[$];

   memory #(.INDEX_W(INDEX_W), .MEM_LAT(MEM_LAT)) i_memory (
      .clk, .rstN, .dataAddr, .wrtData, .memWrt, .readEn, .istall, .istallM,
      .memOut, .done, .cacheHit, .dstall, .dcacheErr
   );

   memChecker i_memChecker (
      .clk, .rstN, .memOut, .done, .cacheHit, .dstall, .dcacheErr, .istall, .istallM,
      .expData, .expHit, .expErr, .checkData, .valueErrs, .otherErrs, .doneCount
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic driveIdle();
      readEn   = 1'b0;
      memWrt   = 1'b0;
      dataAddr = '0;
      wrtData  = '0;
   endtask

   task automatic loadVectors(output bit ok);
      int          fd;
      int          n;
      logic [3:0]  op;
      logic [15:0] a, w, r;
      logic        h, e, s;
      fd = $fopen("verif/memVectors.txt", "r");
      ok = 1'b0;
      if (fd != 0) begin
         n = $fscanf(fd, "%h %h %h %h %h %h %h", op, a, w, r, h, e, s);
         while (n == 7) begin
            vecQ.push_back('{op, a, w, r, h, e, s});
            n = $fscanf(fd, "%h %h %h %h %h %h %h", op, a, w, r, h, e, s);
         end
         $fclose(fd);
         ok = (vecQ.size() > 0);
      end
   endtask

   // one access, held until done, then one idle cycle.
   task automatic runAccess(input vecS v);
      expData   = v.rdata;
      expHit    = v.hit;
      expErr    = v.err;
      checkData = v.op[0] && !v.op[1] && !v.err;   // write wins on op 3.
      dataAddr  = v.addr;
      wrtData   = v.wdata;
      readEn    = v.op[0];
      memWrt    = v.op[1];
      if (v.stall) begin
         istall  = 1'b1;
         istallM = 1'b1;
         repeat (STALL_CYC) @(negedge clk);
         istall  = 1'b0;
         istallM = 1'b0;
      end
      do @(negedge clk); while (!done);
      driveIdle();
      @(negedge clk);
   endtask

   task automatic finishRun(input bit forced);
      $display("errors: %0d value mismatches, %0d other failures",
               valueErrs, otherErrs + tbErrs);
      if (!forced && (valueErrs + otherErrs + tbErrs == 0))
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   endtask

   initial begin
      rstN      = 1'b0;
      istall    = 1'b0;
      istallM   = 1'b0;
      expData   = '0;
      expHit    = 1'b0;
      expErr    = 1'b0;
      checkData = 1'b0;
      driveIdle();
      loadVectors(loaded);
      if (!loaded) begin
         $display("could not read any vectors from verif/memVectors.txt");
         tbErrs++;
         finishRun(1'b1);
      end else begin
         cycleLimit = vecQ.size() * (MEM_LAT + 12) + 50;
         repeat (5) @(negedge clk);
         rstN = 1'b1;
         repeat (2) @(negedge clk);   // let the checker see the idle state first.
         foreach (vecQ[i]) runAccess(vecQ[i]);
         if (doneCount != vecQ.size()) begin
            $display("expected %0d completed accesses but saw %0d", vecQ.size(), doneCount);
            tbErrs++;
         end
         finishRun(1'b0);
      end
   end

   // cycle budget from the vector count.
   initial begin
      cycles = 0;
      wait (cycleLimit > 0);
      while (cycles < cycleLimit) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: the run did not finish within %0d cycles", cycleLimit);
      tbErrs++;
      finishRun(1'b1);
   end

endmodule

`default_nettype wire

// File: verif/memVectors.txt
1 0010 0000 A5AD 0 0 0
1 0010 0000 A5AD 1 0 0
2 0010 1234 0000 1 0 0
1 0010 0000 1234 1 0 0
2 0024 BEEF 0000 0 0 0
1 0024 0000 BEEF 0 0 0
1 0024 0000 BEEF 1 0 0
1 0006 0000 A5A6 0 0 0
1 0016 0000 A5AE 0 0 0
1 0006 0000 A5A6 0 0 0
1 0016 0000 A5AE 0 0 0
1 0007 0000 0000 0 1 0
2 0017 FFFF 0000 0 1 0
1 0016 0000 A5AE 1 0 0
1 0006 0000 A5A6 0 0 0
1 0100 0000 A525 0 0 1
3 0100 5A5A 0000 1 0 0
1 0100 0000 5A5A 1 0 1
1 0010 0000 1234 0 0 0
2 FFFE C0DE 0000 0 0 0
1 FFFE 0000 C0DE 0 0 0
1 0000 0000 A5A5 0 0 0
1 FFFE 0000 C0DE 1 0 0
1 0000 0000 A5A5 1 0 1
1 0011 0000 0000 0 1 1

// File: vlog.f
common/memPkg.sv
dcache/cacheArray.sv
dcache/cacheCtrl.sv
verilog/mainMem.sv
dcache/memSystem.sv
verilog/memory.sv
verif/memChecker.sv
verif/tbMemory.sv
